//--- files.f
+incdir+include
rtl/fetch_pkg.sv
rtl/line_fetch_ctrl.sv
rtl/l0_line_buffer.sv
rtl/instr_aligner.sv
rtl/fetch_top.sv
tb/tb_clkgen.sv
tb/tb_imem_model.sv
tb/tb_fetch.sv

//--- Makefile
# Verilator flow for the instruction fetch front end
# any variable below can be set on the make command line

VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Result: PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP) $(VFLAGS)

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) $(VFLAGS)

# the run passes only when the pass line shows up in the output
sim: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/tb_fetch.sv
////////////////////
// fetch front end testbench
// directed tests for reset state, sequential streams,
// back-pressure, branch redirects and halfword stitching
////////////////////
`timescale 1ns/1ns

module tb_fetch;
  import fetch_pkg::*;

  localparam logic [31:0] SEED         = 32'hfdf611c7;
  localparam word_t       DATA_PATTERN = 32'h5ac3_0f96;  // memory word = address xor this
  localparam int          WAIT_LIMIT   = 60;             // cycles without a valid word

  logic  clk;
  logic  rst_n;
  logic  branch;
  addr_t branch_addr;
  logic  ready;
  logic  unaligned;
  logic  valid;
  word_t rdata;
  addr_t addr;
  logic  busy;
  logic  instr_req;
  addr_t instr_addr;
  logic  instr_gnt;
  logic  instr_rvalid;
  line_t instr_rdata;
  int    test_errors;
  int    total_errors;
  int    tests_passed;
  int    tests_failed;

  tb_clkgen #(.PERIOD(40), .RESET_CYCLES(8)) u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  tb_imem_model #(.DATA_PATTERN(DATA_PATTERN)) u_imem (
    .clk_i (clk), .rst_n_i (rst_n), .req_i (instr_req), .addr_i (instr_addr),
    .gnt_o (instr_gnt), .rvalid_o (instr_rvalid), .rdata_o (instr_rdata)
  );

  fetch_top UUT (
    .clk (clk), .rst_n (rst_n),
    .branch_i (branch), .branch_addr_i (branch_addr), .ready_i (ready),
    .unaligned_i (unaligned), .valid_o (valid), .rdata_o (rdata), .addr_o (addr),
    .busy_o (busy), .instr_req_o (instr_req), .instr_addr_o (instr_addr),
    .instr_gnt_i (instr_gnt), .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata)
  );

  // memory content rule
  function automatic word_t mem_word(input addr_t a);
    return a ^ DATA_PATTERN;
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      test_errors++;
    end
  endtask

  // inputs change on the falling edge, outputs read once settled
  task automatic drive_cycle(input logic rdy, input logic unal);
    @(negedge clk);
    branch    = 1'b0;
    ready     = rdy;
    unaligned = unal;
    #1;
  endtask

  // one cycle branch pulse, the core takes nothing meanwhile
  task automatic do_branch(input addr_t target);
    @(negedge clk);
    branch      = 1'b1;
    branch_addr = target;
    ready       = 1'b0;
    #1;
  endtask

  // consume n words from start on, each must hold still while stalled
  task automatic run_stream(input addr_t start, input int n, input logic rand_ready);
    addr_t exp_addr;
    addr_t last_addr;
    word_t last_data;
    logic  rdy;
    logic  stalled;
    int    got;
    int    idle;
    int    hold;
    exp_addr = start;
    stalled  = 1'b0;
    got      = 0;
    idle     = 0;
    hold     = 0;
    while (got < n && idle < WAIT_LIMIT)
    begin
      if (!rand_ready)
        rdy = 1'b1;
      else if (exp_addr[3:2] == 2'b11 && hold < 10)
        rdy = 1'b0;  // long stall on word 3, prefetch lands meanwhile
      else
        rdy = 1'($urandom % 2);
      drive_cycle(rdy, 1'b0);
      if (stalled)
      begin
        check_bit("valid_o", valid, 1'b1);
        check_word("rdata_o", rdata, last_data);
        check_addr("addr_o", addr, last_addr);
      end
      stalled   = valid & ~rdy;
      last_data = rdata;
      last_addr = addr;
      if (!valid)
        idle++;
      else if (!rdy)
      begin
        idle = 0;
        hold++;
      end
      else
      begin
        idle = 0;
        hold = 0;
        check_addr("addr_o", addr, exp_addr);
        check_word("rdata_o", rdata, mem_word(exp_addr));
        exp_addr = exp_addr + addr_t'(4);
        got++;
      end
    end
    if (got < n)
    begin
      $display("timeout at %0t ns: only %0d of %0d words came out", $time, got, n);
      test_errors++;
    end
  endtask

  // stitched words, prev is the last word taken in aligned mode
  task automatic run_stitched(input addr_t prev, input int n);
    word_t lo_word;
    word_t hi_word;
    int    got;
    int    idle;
    got  = 0;
    idle = 0;
    while (got < n && idle < WAIT_LIMIT)
    begin
      drive_cycle(1'b1, 1'b1);
      if (!valid)
        idle++;
      else
      begin
        idle    = 0;
        lo_word = mem_word(prev + addr_t'(4));
        hi_word = mem_word(prev);
        check_addr("addr_o", addr, prev + addr_t'(2));
        check_word("rdata_o", rdata, {lo_word[15:0], hi_word[31:16]});
        prev = prev + addr_t'(4);
        got++;
      end
    end
    if (got < n)
    begin
      $display("timeout at %0t ns: only %0d of %0d stitched words", $time, got, n);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, test_errors);
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial
  begin
    int n;
    n            = $urandom(SEED);
    branch       = 1'b0;
    branch_addr  = '0;
    ready        = 1'b0;
    unaligned    = 1'b0;
    test_errors  = 0;
    total_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    n            = 0;
    while (!rst_n && n < 20)
    begin
      @(negedge clk);
      n++;
    end
    if (!rst_n)
    begin
      $display("reset was never released");
      test_errors++;
    end

    // quiet after reset, nothing starts without a branch
    repeat (10)
    begin
      drive_cycle(1'b1, 1'b0);
      check_bit("valid_o", valid, 1'b0);
      check_bit("instr_req_o", instr_req, 1'b0);
      check_bit("busy_o", busy, 1'b0);
    end
    end_test("reset_idle");

    do_branch(32'h0000_1008);
    check_bit("instr_req_o", instr_req, 1'b1);              // request in the branch cycle
    check_addr("instr_addr_o", instr_addr, 32'h0000_1000);  // line aligned target
    run_stream(32'h0000_1008, 16, 1'b0);  // crosses four line boundaries
    end_test("sequential_stream");

    do_branch(32'h0000_2004);
    run_stream(32'h0000_2004, 24, 1'b1);
    end_test("back_pressure");

    do_branch(32'h0000_3000);
    run_stream(32'h0000_3000, 2, 1'b0);
    do_branch(32'h0000_3104);             // mid line redirect
    run_stream(32'h0000_3104, 3, 1'b0);
    do_branch(32'h0000_4000);
    do_branch(32'h0000_420c);             // first line still in flight
    check_bit("busy_o", busy, 1'b1);
    drive_cycle(1'b1, 1'b0);
    check_bit("valid_o", valid, 1'b0);
    run_stream(32'h0000_420c, 1, 1'b0);
    do_branch(32'h0000_5008);             // prefetch of 0x4210 may be pending
    run_stream(32'h0000_5008, 6, 1'b0);
    end_test("branch_redirect");

    do_branch(32'h0000_6000);
    repeat (12)
    begin
      drive_cycle(1'b1, 1'b1);
      check_bit("valid_o", valid, 1'b0);  // no upper half held yet
    end
    run_stream(32'h0000_6000, 1, 1'b0);
    run_stitched(32'h0000_6000, 6);
    end_test("halfword_stitch");

    $display("summary: %0d tests passed, %0d failed, %0d errors",
             tests_passed, tests_failed, total_errors);
    if (tests_failed == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- tb/tb_imem_model.sv
////////////////////
// instruction memory model
// req/gnt/rvalid slave with random grant and response delays
// word at byte address A reads as A xor a fixed pattern
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

module tb_imem_model #(
  parameter fetch_pkg::word_t DATA_PATTERN = '0
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_i,
  input  fetch_pkg::addr_t addr_i,
  output logic             gnt_o,
  output logic             rvalid_o,
  output fetch_pkg::line_t rdata_o
);
  import fetch_pkg::*;

  logic [1:0] gnt_wait_q;   // request cycles left before the grant
  logic [1:0] rv_wait_q;    // cycles left before the response
  logic       pending_q;    // one granted line in flight
  addr_t      line_addr_q;

  // build one line from the address rule
  function automatic line_t make_line(input addr_t base);
    line_t l;
    for (int i = 0; i < `FETCH_LINE_WORDS; i++)
      l[i] = (base + addr_t'(4 * i)) ^ DATA_PATTERN;
    return l;
  endfunction

  assign gnt_o    = (gnt_wait_q == 2'd0);  // may sit high ahead of a request
  assign rvalid_o = pending_q && (rv_wait_q == 2'd0);
  assign rdata_o  = make_line(line_addr_q);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      gnt_wait_q  <= 2'd0;
      rv_wait_q   <= 2'd0;
      pending_q   <= 1'b0;
      line_addr_q <= '0;
    end
    else
    begin
      if (rvalid_o)
        pending_q <= 1'b0;                 // response done
      else if (pending_q)
        rv_wait_q <= rv_wait_q - 2'd1;
      if (req_i && gnt_o)
      begin
        pending_q   <= 1'b1;               // accepted, new delays for next time
        line_addr_q <= addr_i;
        rv_wait_q   <= 2'($urandom % 4);
        gnt_wait_q  <= 2'($urandom % 4);
      end
      else if (req_i)
        gnt_wait_q <= gnt_wait_q - 2'd1;  // counts only while asked
    end
  end

endmodule

//--- tb/tb_clkgen.sv
////////////////////
// testbench clock and reset
// free running clock, reset held low for a few cycles
////////////////////
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // release away from the active edge
  end

endmodule

//--- rtl/fetch_top.sv
////////////////////
// instruction fetch front end
// line controller, L0 buffer and aligner between
// the core valid/ready port and req/gnt/rvalid memory
////////////////////
`timescale 1ns/1ns

module fetch_top (
  input  logic             clk,
  input  logic             rst_n,
  // core side
  input  logic             branch_i,
  input  fetch_pkg::addr_t branch_addr_i,
  input  logic             ready_i,
  input  logic             unaligned_i,
  output logic             valid_o,
  output fetch_pkg::word_t rdata_o,
  output fetch_pkg::addr_t addr_o,
  output logic             busy_o,
  // memory side
  output logic             instr_req_o,
  output fetch_pkg::addr_t instr_addr_o,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  input  fetch_pkg::line_t instr_rdata_i
);
  import fetch_pkg::*;

  logic  need_next;
  logic  line_load;
  addr_t line_base;
  logic  prefetch;
  logic  buf_valid;
  word_t buf_word;
  addr_t buf_addr;
  logic  buf_ready;

  line_fetch_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .need_next_i    (need_next),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .line_load_o    (line_load),
    .line_base_o    (line_base),
    .prefetch_o     (prefetch),
    .busy_o         (busy_o)
  );

  l0_line_buffer u_buf (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .line_load_i   (line_load),
    .line_base_i   (line_base),
    .prefetch_i    (prefetch),
    .instr_rdata_i (instr_rdata_i),
    .buf_ready_i   (buf_ready),
    .need_next_o   (need_next),
    .buf_valid_o   (buf_valid),
    .buf_word_o    (buf_word),
    .buf_addr_o    (buf_addr)
  );

  instr_aligner u_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .branch_i    (branch_i),
    .unaligned_i (unaligned_i),
    .buf_valid_i (buf_valid),
    .buf_word_i  (buf_word),
    .buf_addr_i  (buf_addr),
    .buf_ready_o (buf_ready),
    .ready_i     (ready_i),
    .valid_o     (valid_o),
    .rdata_o     (rdata_o),
    .addr_o      (addr_o)
  );

endmodule

//--- rtl/instr_aligner.sv
////////////////////
// instruction aligner
// passes buffer words through, or stitches a
// halfword aligned instruction from two words
////////////////////
`timescale 1ns/1ns

module instr_aligner (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             branch_i,
  input  logic             unaligned_i,
  input  logic             buf_valid_i,
  input  fetch_pkg::word_t buf_word_i,
  input  fetch_pkg::addr_t buf_addr_i,
  output logic             buf_ready_o,
  input  logic             ready_i,
  output logic             valid_o,
  output fetch_pkg::word_t rdata_o,
  output fetch_pkg::addr_t addr_o
);
  import fetch_pkg::*;

  logic [15:0] held_half_q;   // upper half of the last consumed word
  addr_t       held_addr_q;   // address of that word
  logic        held_valid_q;
  logic        can_issue;
  logic        consume;

  // stitching needs a previous word since the last branch
  assign can_issue = ~unaligned_i | held_valid_q;

  assign valid_o     = buf_valid_i & can_issue;
  assign buf_ready_o = ready_i & can_issue;
  assign consume     = valid_o & ready_i;

  ////////////////////
  // output mux
  ////////////////////
  always_comb
  begin
    if (unaligned_i)
    begin
      rdata_o = {buf_word_i[15:0], held_half_q};  // low half of current on top
      addr_o  = held_addr_q + addr_t'(2);
    end
    else
    begin
      rdata_o = buf_word_i;
      addr_o  = buf_addr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      held_valid_q <= 1'b0;
    else if (branch_i)
      held_valid_q <= 1'b0;  // old half belongs to the old stream
    else if (consume)
      held_valid_q <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (consume)
    begin
      held_half_q <= buf_word_i[31:16];
      held_addr_q <= buf_addr_i;
    end
  end

endmodule

//--- rtl/l0_line_buffer.sv
////////////////////
// L0 line buffer
// holds the current line and walks the word pointer
// word 3 is kept aside when a prefetch overwrites the line
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

module l0_line_buffer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             branch_i,
  input  fetch_pkg::addr_t branch_addr_i,
  input  logic             line_load_i,
  input  fetch_pkg::addr_t line_base_i,
  input  logic             prefetch_i,
  input  fetch_pkg::line_t instr_rdata_i,
  input  logic             buf_ready_i,
  output logic             need_next_o,
  output logic             buf_valid_o,
  output fetch_pkg::word_t buf_word_o,
  output fetch_pkg::addr_t buf_addr_o
);
  import fetch_pkg::*;

  line_t      line_q;
  addr_t      base_q;
  logic [1:0] ptr_q;          // word within the line
  logic       line_valid_q;   // line_q[ptr_q] not yet consumed
  word_t      saved_word_q;   // old word 3 after a prefetch overwrite
  addr_t      saved_addr_q;
  logic       saved_valid_q;
  logic       next_req_q;     // next line already asked for
  logic       on_last;
  logic       hs;
  logic       keep_last;

  assign on_last   = (ptr_q == 2'(`FETCH_LINE_WORDS - 1));
  assign hs        = buf_valid_o & buf_ready_i;
  assign keep_last = line_valid_q & on_last & ~hs;  // word 3 still pending

  assign need_next_o = line_valid_q & on_last & ~next_req_q;
  assign buf_valid_o = saved_valid_q | line_valid_q;
  assign buf_word_o  = saved_valid_q ? saved_word_q : line_q[ptr_q];
  assign buf_addr_o  = saved_valid_q ? saved_addr_q
                                     : {base_q[`FETCH_ADDR_W-1:4], ptr_q, 2'b00};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ptr_q         <= '0;
      line_valid_q  <= 1'b0;
      saved_valid_q <= 1'b0;
      next_req_q    <= 1'b0;
    end
    else if (branch_i)
    begin
      ptr_q         <= branch_addr_i[3:2];  // start at the target word
      line_valid_q  <= 1'b0;
      saved_valid_q <= 1'b0;
      next_req_q    <= 1'b0;
    end
    else
    begin
      if (need_next_o)
        next_req_q <= 1'b1;
      if (hs && saved_valid_q)
        saved_valid_q <= 1'b0;   // saved word goes first
      else if (hs)
      begin
        ptr_q <= ptr_q + 2'd1;
        if (on_last)
          line_valid_q <= 1'b0;  // line used up, wait for prefetch
      end
      if (line_load_i)
      begin
        line_valid_q <= 1'b1;
        if (prefetch_i)
        begin
          ptr_q      <= '0;
          next_req_q <= 1'b0;
          if (keep_last)
            saved_valid_q <= 1'b1;
        end
      end
    end
  end

  // line and saved word storage
  always_ff @(posedge clk)
  begin
    if (line_load_i)
    begin
      line_q <= instr_rdata_i;
      base_q <= line_base_i;
    end
    if (line_load_i && prefetch_i && keep_last)
    begin
      saved_word_q <= line_q[`FETCH_LINE_WORDS-1];
      saved_addr_q <= {base_q[`FETCH_ADDR_W-1:4], 2'b11, 2'b00};
    end
  end

  // a stalled word stays put, also across a prefetch overwrite
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    buf_valid_o && !buf_ready_i && !branch_i
    |=> buf_valid_o && $stable(buf_word_o) && $stable(buf_addr_o));

endmodule

//--- rtl/line_fetch_ctrl.sv
////////////////////
// line fetch controller
// issues line requests over req/gnt/rvalid, one at a time
// handles branch targets, next-line prefetch and aborts
// a stale response is waited for and dropped
////////////////////
`timescale 1ns/1ns
`include "fetch_defines.svh"

module line_fetch_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             branch_i,
  input  fetch_pkg::addr_t branch_addr_i,
  input  logic             need_next_i,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  output logic             instr_req_o,
  output fetch_pkg::addr_t instr_addr_o,
  output logic             line_load_o,
  output fetch_pkg::addr_t line_base_o,
  output logic             prefetch_o,
  output logic             busy_o
);
  import fetch_pkg::*;

  fetch_state_e state_q, state_d;
  addr_t        req_addr_q;              // line in flight
  addr_t        tgt_addr_q, tgt_addr_d;  // line the stream is on
  logic         pref_q;                  // request in flight is a prefetch
  logic         stale_q, stale_d;        // branch seen before the grant
  addr_t        branch_line;
  addr_t        next_line;
  logic         issue;                   // new request starts this cycle
  logic         issue_pref;

  assign branch_line = {branch_addr_i[`FETCH_ADDR_W-1:4], 4'b0000};
  assign next_line   = tgt_addr_q + addr_t'(`FETCH_LINE_W / 8);

  ////////////////////
  // next state
  ////////////////////
  always_comb
  begin
    state_d      = state_q;
    tgt_addr_d   = tgt_addr_q;
    stale_d      = stale_q;
    instr_req_o  = 1'b0;
    instr_addr_o = branch_line;
    issue        = 1'b0;
    issue_pref   = 1'b0;
    line_load_o  = 1'b0;

    case (state_q)
      IDLE:
      begin
        if (branch_i)
        begin
          issue      = 1'b1;  // same cycle as the branch
          tgt_addr_d = branch_line;
        end
        else if (need_next_i)
        begin
          issue        = 1'b1;
          issue_pref   = 1'b1;
          instr_addr_o = next_line;
          tgt_addr_d   = next_line;
        end
      end
      WAIT_GNT:
      begin
        instr_req_o  = 1'b1;
        instr_addr_o = req_addr_q;  // held until granted
        if (branch_i)
        begin
          stale_d    = 1'b1;  // finish the handshake, drop the data later
          tgt_addr_d = branch_line;
        end
        if (instr_gnt_i)
          state_d = (stale_q || branch_i) ? WAIT_ABORTED : WAIT_RVALID;
      end
      WAIT_RVALID:
      begin
        if (branch_i)
        begin
          tgt_addr_d = branch_line;
          if (instr_rvalid_i)
            issue = 1'b1;  // stale data arrives now, restart at once
          else
            state_d = WAIT_ABORTED;
        end
        else if (instr_rvalid_i)
        begin
          line_load_o = 1'b1;
          state_d     = IDLE;
        end
      end
      WAIT_ABORTED:
      begin
        if (branch_i)
          tgt_addr_d = branch_line;  // newest target wins
        else
          instr_addr_o = tgt_addr_q;
        if (instr_rvalid_i)
          issue = 1'b1;  // response dropped
      end
      default: state_d = IDLE;
    endcase

    if (issue)
    begin
      instr_req_o = 1'b1;
      stale_d     = 1'b0;
      state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      stale_q <= 1'b0;
      pref_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      stale_q <= stale_d;
      if (issue)
        pref_q <= issue_pref;
    end
  end

  // line addresses
  always_ff @(posedge clk)
  begin
    tgt_addr_q <= tgt_addr_d;
    if (issue)
      req_addr_q <= instr_addr_o;
  end

  assign line_base_o = req_addr_q;
  assign prefetch_o  = pref_q;
  assign busy_o      = (state_q != IDLE) || instr_req_o;

  ////////////////////
  // protocol checks
  ////////////////////
  // an ungranted request stays up with the same line address
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  // memory never answers without a granted request
  a_no_idle_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    state_q == IDLE |-> !instr_rvalid_i);

endmodule

//--- rtl/fetch_pkg.sv
////////////////////
// fetch package
// word, address and line types shared by the fetch blocks
// plus the state encoding of the line controller
////////////////////
`include "fetch_defines.svh"

package fetch_pkg;

  // one instruction word
  typedef logic [`FETCH_WORD_W-1:0] word_t;

  // byte address, lines are 16 byte aligned
  typedef logic [`FETCH_ADDR_W-1:0] addr_t;

  // one cache line, word 0 sits in the low bits
  typedef word_t [`FETCH_LINE_WORDS-1:0] line_t;

  // line controller states
  typedef enum logic [1:0] {
    IDLE         = 2'b00,  // nothing outstanding
    WAIT_GNT     = 2'b01,  // req high, waiting for memory to take it
    WAIT_RVALID  = 2'b10,  // granted, response still to come
    WAIT_ABORTED = 2'b11   // granted but stale, drop the response
  } fetch_state_e;

endpackage

//--- include/fetch_defines.svh
////////////////////
// fetch geometry
// address, word and line sizes for the fetch front end
// pointer and offset logic assume four words per line
////////////////////
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// byte address width
`define FETCH_ADDR_W     32
// one instruction word
`define FETCH_WORD_W     32
// words per cache line
`define FETCH_LINE_WORDS 4
// full line as returned by memory
`define FETCH_LINE_W     (`FETCH_WORD_W * `FETCH_LINE_WORDS)

`endif
